/* source/pmp_params.svh */
/* Build-time constants of the pre-modulation processor: phase count, PWM block base
   address and the per-channel register map. Include wherever these values are needed */
`ifndef PMP_PARAMS_SVH
`define PMP_PARAMS_SVH

// Number of phase legs, one PWM channel each
`define PMP_N_PHASES 4

// Base address of the PWM register block and distance between channels
`define PMP_PWM_BASE_ADDR 16'h0000
`define PMP_PHASE_STRIDE 16'd16

// Register offsets inside one channel
`define PMP_REG_CTRL 16'd0
`define PMP_REG_DEADTIME 16'd4
`define PMP_REG_ON 16'd8
`define PMP_REG_OFF 16'd12

// Control word values
`define PMP_CTRL_ENABLE 32'd1
`define PMP_CTRL_RUN 32'd2

`endif

/* source/pmp_pkg.sv */
/* Types shared by the pre-modulation processor blocks and its testbench.
   Referenced with scoped names, sized by the phase count in the params header */
`include "pmp_params.svh"

package pmp_pkg;

    // One register write on the outgoing stream
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
        // High on the final write of a sequence
        logic last;
    } write_req_t;

    // Modulation settings from the controller
    typedef struct packed {
        logic [`PMP_N_PHASES-1:0][15:0] duty;
        logic [15:0] deadtime;
        // Active phase count minus one
        logic [2:0] n_active;
    } mod_params_t;

    // Duty actually written to a phase, reported after its OFF write
    typedef struct packed {
        logic [1:0] phase;
        logic [15:0] duty;
    } duty_report_t;

endpackage

/* source/pmp_shift_calculator.sv */
/* Computes the phase shift of every leg as i * floor(period / active count).
   A serial restoring divider restarts whenever period or n_active changes */
`timescale 1ns/10ps
`include "pmp_params.svh"

module pmp_shift_calculator #(
    parameter int N_PHASES = `PMP_N_PHASES
) (
    input  logic clock,
    input  logic rst_n,
    input  logic [15:0] period,
    input  logic [2:0] n_active,
    output logic [N_PHASES-1:0][15:0] phase_shifts,
    output logic shifts_ready
);

    typedef enum logic [1:0] {SC_IDLE, SC_DIV, SC_BUILD} sc_state_t;

    sc_state_t state;
    logic primed;
    logic restart;
    logic [3:0] step;
    logic [15:0] period_q;
    logic [2:0] n_active_q;
    logic [3:0] divisor;
    logic [3:0] rem;
    logic [15:0] quo;
    logic [4:0] rem_shift;
    logic [N_PHASES-1:0][15:0] shift_acc;

    // A fresh computation is needed after reset and on any input change
    assign restart = !primed || (period != period_q) || (n_active != n_active_q);
    assign rem_shift = {rem, quo[15]};

    // Shift of phase i is built by adding the quotient i times
    always_comb begin
        shift_acc[0] = '0;
        for (int i = 1; i < N_PHASES; i++) begin
            shift_acc[i] = shift_acc[i-1] + quo;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= SC_IDLE;
            primed <= 1'b0;
            step <= '0;
            shifts_ready <= 1'b0;
        end else if (restart) begin
            state <= SC_DIV;
            primed <= 1'b1;
            step <= '0;
            shifts_ready <= 1'b0;
        end else begin
            case (state)
                SC_DIV: begin
                    step <= step + 4'd1;
                    if (step == 4'd15) begin
                        state <= SC_BUILD;
                    end
                end
                SC_BUILD: begin
                    state <= SC_IDLE;
                    shifts_ready <= 1'b1;
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

    // Divider datapath, the quotient shifts in where the dividend shifts out
    always_ff @(posedge clock) begin
        period_q <= period;
        n_active_q <= n_active;
        if (restart) begin
            quo <= period;
            rem <= '0;
            divisor <= {1'b0, n_active} + 4'd1;
        end else if (state == SC_DIV) begin
            if (rem_shift >= {1'b0, divisor}) begin
                rem <= 4'(rem_shift - {1'b0, divisor});
                quo <= {quo[14:0], 1'b1};
            end else begin
                rem <= rem_shift[3:0];
                quo <= {quo[14:0], 1'b0};
            end
        end else if (state == SC_BUILD) begin
            phase_shifts <= shift_acc;
        end
    end

endmodule

/* source/pmp_phase_shedder.sv */
/* Limits each phase duty to the period and zeroes the duty of shed phases.
   Output is registered, one cycle behind its inputs */
`timescale 1ns/10ps
`include "pmp_params.svh"

module pmp_phase_shedder #(
    parameter int N_PHASES = `PMP_N_PHASES
) (
    input  logic clock,
    input  logic rst_n,
    input  logic [15:0] period,
    input  pmp_pkg::mod_params_t params,
    output logic [N_PHASES-1:0][15:0] duty_shed
);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            duty_shed <= '0;
        end else begin
            for (int i = 0; i < N_PHASES; i++) begin
                // Phases above the active count are turned off
                if (i > int'(params.n_active)) begin
                    duty_shed[i] <= '0;
                end else if (params.duty[i] > period) begin
                    duty_shed[i] <= period;
                end else begin
                    duty_shed[i] <= params.duty[i];
                end
            end
        end
    end

endmodule

/* source/pmp_management_core.sv */
/* Control FSM that writes the channel configuration and the start and stop
   control words, one phase after the other, on its own write stream */
`timescale 1ns/10ps
`include "pmp_params.svh"

module pmp_management_core #(
    parameter int N_PHASES = `PMP_N_PHASES,
    parameter logic [15:0] PWM_BASE_ADDR = `PMP_PWM_BASE_ADDR
) (
    input  logic clock,
    input  logic rst_n,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic [15:0] deadtime,
    output pmp_pkg::write_req_t req,
    output logic req_valid,
    input  logic req_ready,
    output logic done,
    output logic config_done,
    output logic running
);

    localparam int CW = $clog2(2 * N_PHASES);

    typedef enum logic [1:0] {MG_IDLE, MG_CFG, MG_RUN, MG_HALT} mg_state_t;

    mg_state_t state;
    logic [CW-1:0] cnt;
    logic [CW-1:0] cnt_last;
    logic [CW-1:0] phase_idx;
    logic [15:0] reg_off;

    // Payload depends only on state and counter, so it holds while stalled
    always_comb begin
        phase_idx = cnt;
        cnt_last = CW'(N_PHASES - 1);
        reg_off = `PMP_REG_CTRL;
        req.data = `PMP_CTRL_ENABLE;
        case (state)
            MG_CFG: begin
                // Two writes per phase, deadtime on even counts
                phase_idx = cnt >> 1;
                cnt_last = CW'(2 * N_PHASES - 1);
                if (!cnt[0]) begin
                    reg_off = `PMP_REG_DEADTIME;
                    req.data = {16'h0000, deadtime};
                end
            end
            MG_RUN: req.data = `PMP_CTRL_RUN;
            default: ;
        endcase
        req.addr = PWM_BASE_ADDR + 16'(phase_idx) * `PMP_PHASE_STRIDE + reg_off;
        req.last = (cnt == cnt_last);
        req_valid = (state != MG_IDLE);
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= MG_IDLE;
            cnt <= '0;
            done <= 1'b0;
            config_done <= 1'b0;
            running <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MG_IDLE: begin
                    cnt <= '0;
                    if (configure && !running) begin
                        state <= MG_CFG;
                        config_done <= 1'b0;
                    end else if (start && config_done && !running) begin
                        state <= MG_RUN;
                    end else if (stop && running) begin
                        state <= MG_HALT;
                    end
                end
                default: begin
                    if (req_ready) begin
                        if (cnt == cnt_last) begin
                            state <= MG_IDLE;
                            cnt <= '0;
                            if (state == MG_CFG) begin
                                done <= 1'b1;
                                config_done <= 1'b1;
                            end
                            running <= (state == MG_RUN);
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* source/pmp_operating_core.sv */
/* Serves per-phase update requests with an ON and an OFF compare write.
   Lowest pending phase first, and a duty report follows each served phase */
`timescale 1ns/10ps
`include "pmp_params.svh"

module pmp_operating_core #(
    parameter int N_PHASES = `PMP_N_PHASES,
    parameter logic [15:0] PWM_BASE_ADDR = `PMP_PWM_BASE_ADDR
) (
    input  logic clock,
    input  logic rst_n,
    input  logic [N_PHASES-1:0] update,
    input  logic running,
    input  logic shifts_ready,
    input  logic [15:0] period,
    input  logic [N_PHASES-1:0][15:0] phase_shifts,
    input  logic [N_PHASES-1:0][15:0] duty_shed,
    output pmp_pkg::write_req_t req,
    output logic req_valid,
    input  logic req_ready,
    output pmp_pkg::duty_report_t duty_report,
    output logic duty_report_valid
);

    localparam int PW = (N_PHASES > 1) ? $clog2(N_PHASES) : 1;

    typedef enum logic [1:0] {OP_IDLE, OP_ON, OP_OFF} op_state_t;

    op_state_t state;
    logic [N_PHASES-1:0] pending;
    logic [N_PHASES-1:0] served_mask;
    logic [PW-1:0] pick;
    logic serve;
    logic [16:0] off_sum;
    logic [15:0] off_val;
    logic [15:0] off_q;
    logic [15:0] chan_addr;

    always_comb begin
        // Walk down so the lowest pending index is the one kept
        pick = '0;
        for (int i = N_PHASES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = PW'(i);
            end
        end
        serve = (state == OP_IDLE) && (|pending) && running && shifts_ready;
        served_mask = serve ? (N_PHASES'(1) << pick) : '0;
        // OFF point wraps around the end of the period
        off_sum = {1'b0, phase_shifts[pick]} + {1'b0, duty_shed[pick]};
        if (off_sum >= {1'b0, period}) begin
            off_val = 16'(off_sum - {1'b0, period});
        end else begin
            off_val = off_sum[15:0];
        end
        chan_addr = PWM_BASE_ADDR + 16'(pick) * `PMP_PHASE_STRIDE;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= OP_IDLE;
            pending <= '0;
            req_valid <= 1'b0;
            duty_report_valid <= 1'b0;
        end else begin
            // A new update for the served phase queues it again
            pending <= (pending & ~served_mask) | update;
            duty_report_valid <= 1'b0;
            case (state)
                OP_IDLE: begin
                    if (serve) begin
                        state <= OP_ON;
                        req_valid <= 1'b1;
                    end
                end
                OP_ON: begin
                    if (req_ready) begin
                        state <= OP_OFF;
                    end
                end
                OP_OFF: begin
                    if (req_ready) begin
                        state <= OP_IDLE;
                        req_valid <= 1'b0;
                        duty_report_valid <= 1'b1;
                    end
                end
                default: state <= OP_IDLE;
            endcase
        end
    end

    // Both writes and the report are captured at pick time
    always_ff @(posedge clock) begin
        if (serve) begin
            req.addr <= chan_addr + `PMP_REG_ON;
            req.data <= {16'h0000, phase_shifts[pick]};
            req.last <= 1'b0;
            off_q <= off_val;
            duty_report.phase <= 2'(pick);
            duty_report.duty <= duty_shed[pick];
        end else if (state == OP_ON && req_ready) begin
            req.addr <= req.addr + (`PMP_REG_OFF - `PMP_REG_ON);
            req.data <= {16'h0000, off_q};
            req.last <= 1'b1;
        end
    end

endmodule

/* source/buck_pre_modulation_processor.sv */
/* Top level of the buck pre-modulation processor. Connects the datapath blocks
   and merges management and operating writes onto one valid/ready stream */
`timescale 1ns/10ps
`include "pmp_params.svh"

module buck_pre_modulation_processor #(
    parameter int N_PHASES = `PMP_N_PHASES,
    parameter logic [15:0] PWM_BASE_ADDR = `PMP_PWM_BASE_ADDR
) (
    input  logic clock,
    input  logic rst_n,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic [N_PHASES-1:0] update,
    input  logic [15:0] period,
    input  pmp_pkg::mod_params_t mod_params,
    output logic done,
    output logic modulator_status,
    output pmp_pkg::duty_report_t duty_report,
    output logic duty_report_valid,
    output pmp_pkg::write_req_t write_req,
    output logic write_valid,
    input  logic write_ready
);

    pmp_pkg::write_req_t mgmt_req;
    logic mgmt_valid;
    logic mgmt_ready;
    pmp_pkg::write_req_t op_req;
    logic op_valid;
    logic op_ready;
    logic [N_PHASES-1:0][15:0] phase_shifts;
    logic [N_PHASES-1:0][15:0] duty_shed;
    logic shifts_ready;
    logic config_done;
    logic op_enable;

    // Operating writes start only while no management write is waiting,
    // so the merged payload never switches under back-pressure
    assign op_enable = modulator_status && config_done && !mgmt_valid;

    pmp_shift_calculator #(
        .N_PHASES(N_PHASES)
    ) u_shift_calc (
        .clock(clock),
        .rst_n(rst_n),
        .period(period),
        .n_active(mod_params.n_active),
        .phase_shifts(phase_shifts),
        .shifts_ready(shifts_ready)
    );

    pmp_phase_shedder #(
        .N_PHASES(N_PHASES)
    ) u_shedder (
        .clock(clock),
        .rst_n(rst_n),
        .period(period),
        .params(mod_params),
        .duty_shed(duty_shed)
    );

    pmp_management_core #(
        .N_PHASES(N_PHASES),
        .PWM_BASE_ADDR(PWM_BASE_ADDR)
    ) u_management_core (
        .clock(clock),
        .rst_n(rst_n),
        .configure(configure),
        .start(start),
        .stop(stop),
        .deadtime(mod_params.deadtime),
        .req(mgmt_req),
        .req_valid(mgmt_valid),
        .req_ready(mgmt_ready),
        .done(done),
        .config_done(config_done),
        .running(modulator_status)
    );

    pmp_operating_core #(
        .N_PHASES(N_PHASES),
        .PWM_BASE_ADDR(PWM_BASE_ADDR)
    ) u_operating_core (
        .clock(clock),
        .rst_n(rst_n),
        .update(update),
        .running(op_enable),
        .shifts_ready(shifts_ready),
        .period(period),
        .phase_shifts(phase_shifts),
        .duty_shed(duty_shed),
        .req(op_req),
        .req_valid(op_valid),
        .req_ready(op_ready),
        .duty_report(duty_report),
        .duty_report_valid(duty_report_valid)
    );

    // Operating writes win, and only the selected source sees ready
    always_comb begin
        op_ready = 1'b0;
        mgmt_ready = 1'b0;
        if (op_valid) begin
            write_req = op_req;
            write_valid = 1'b1;
            op_ready = write_ready;
        end else begin
            write_req = mgmt_req;
            write_valid = mgmt_valid;
            mgmt_ready = write_ready;
        end
    end

endmodule

/* tests/pmp_checker.sv */
/* Assertions for the write stream and the done strobe of the pre-modulation
   processor. Attached to the top level with bind from the testbench */
`timescale 1ns/10ps

module pmp_checker (
    input  logic clock,
    input  logic rst_n,
    input  pmp_pkg::write_req_t write_req,
    input  logic write_valid,
    input  logic write_ready,
    input  logic done
);

    // A stalled write keeps its valid and its payload until it is taken
    a_stall_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (write_valid && !write_ready) |=> (write_valid && $stable(write_req))
    ) else $error("Write stream changed while stalled");

    // Done marks the end of a configure sequence for exactly one cycle
    a_done_pulse: assert property (
        @(posedge clock) disable iff (!rst_n)
        done |=> !done
    ) else $error("Done held high for more than one cycle");

    // Registers are cleared by the first reset edge
    a_reset_quiet: assert property (
        @(posedge clock)
        !rst_n |=> !write_valid
    ) else $error("Write valid high during reset");

endmodule

/* tests/tb_pmp.sv */
/* Testbench for the buck pre-modulation processor. Drives command strobes and
   phase updates, and checks every accepted write and duty report in order */
`timescale 1ns/10ps
`include "pmp_params.svh"

module tb_pmp;

    localparam int N = `PMP_N_PHASES;
    localparam int CMD_CONFIG = 0;
    localparam int CMD_START = 1;
    localparam int CMD_STOP = 2;
    localparam int CMD_UPDATE = 3;

    logic clock;
    logic rst_n;
    logic configure;
    logic start;
    logic stop;
    logic [N-1:0] update;
    logic [15:0] period;
    pmp_pkg::mod_params_t mod_params;
    logic done;
    logic modulator_status;
    pmp_pkg::duty_report_t duty_report;
    logic duty_report_valid;
    pmp_pkg::write_req_t write_req;
    logic write_valid;
    logic write_ready;

    pmp_pkg::write_req_t exp_q[$];
    pmp_pkg::write_req_t got_q[$];
    pmp_pkg::duty_report_t rep_exp_q[$];
    pmp_pkg::duty_report_t rep_got_q[$];
    int done_count = 0;
    int write_count = 0;
    int error_count = 0;
    logic random_ready;
    logic [31:0] duty_rng;
    logic [31:0] ready_rng;
    string test_name;

    buck_pre_modulation_processor u_dut (
        .clock(clock),
        .rst_n(rst_n),
        .configure(configure),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .mod_params(mod_params),
        .done(done),
        .modulator_status(modulator_status),
        .duty_report(duty_report),
        .duty_report_valid(duty_report_valid),
        .write_req(write_req),
        .write_valid(write_valid),
        .write_ready(write_ready)
    );

    bind buck_pre_modulation_processor pmp_checker u_checker (
        .clock(clock),
        .rst_n(rst_n),
        .write_req(write_req),
        .write_valid(write_valid),
        .write_ready(write_ready),
        .done(done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] random_duty();
        duty_rng = xorshift32(duty_rng);
        // Range reaches past the period so clamping is exercised too
        return 16'(duty_rng % 32'd1200);
    endfunction

    // Shed phases get zero, active ones are limited to the period
    function automatic int shed_duty(input int phase, input logic [15:0] per,
            input pmp_pkg::mod_params_t mp);
        if (phase > int'(mp.n_active)) begin
            return 0;
        end
        if (int'(mp.duty[phase]) > int'(per)) begin
            return int'(per);
        end
        return int'(mp.duty[phase]);
    endfunction

    // Expected write number idx of a command sequence
    function automatic pmp_pkg::write_req_t expected_write(input int cmd, input int idx,
            input logic [15:0] per, input pmp_pkg::mod_params_t mp);
        pmp_pkg::write_req_t w;
        int phase;
        int chan;
        int shift;
        int off;
        phase = (cmd == CMD_CONFIG || cmd == CMD_UPDATE) ? idx / 2 : idx;
        chan = int'(`PMP_PWM_BASE_ADDR) + phase * int'(`PMP_PHASE_STRIDE);
        w.last = 1'b0;
        case (cmd)
            CMD_CONFIG: begin
                if (idx % 2 == 0) begin
                    w.addr = 16'(chan + int'(`PMP_REG_DEADTIME));
                    w.data = {16'h0000, mp.deadtime};
                end else begin
                    w.addr = 16'(chan + int'(`PMP_REG_CTRL));
                    w.data = `PMP_CTRL_ENABLE;
                end
                w.last = (idx == 2 * N - 1);
            end
            CMD_START, CMD_STOP: begin
                w.addr = 16'(chan + int'(`PMP_REG_CTRL));
                w.data = (cmd == CMD_START) ? `PMP_CTRL_RUN : `PMP_CTRL_ENABLE;
                w.last = (idx == N - 1);
            end
            default: begin
                shift = phase * (int'(per) / (int'(mp.n_active) + 1));
                if (idx % 2 == 0) begin
                    w.addr = 16'(chan + int'(`PMP_REG_ON));
                    w.data = 32'(shift);
                end else begin
                    // OFF point wraps back into the period
                    off = shift + shed_duty(phase, per, mp);
                    if (off >= int'(per)) begin
                        off = off - int'(per);
                    end
                    w.addr = 16'(chan + int'(`PMP_REG_OFF));
                    w.data = 32'(off);
                    w.last = 1'b1;
                end
            end
        endcase
        return w;
    endfunction

    task automatic abort_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s %s expected %0h actual %0h",
                test_name, what, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic pulse_command(input int cmd);
        next_cycle();
        configure = (cmd == CMD_CONFIG);
        start = (cmd == CMD_START);
        stop = (cmd == CMD_STOP);
        next_cycle();
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
    endtask

    task automatic issue_update(input logic [N-1:0] mask);
        next_cycle();
        update = mask;
        next_cycle();
        update = '0;
    endtask

    // Queues the writes and reports a command should produce, in arrival order
    task automatic expect_sequence(input int cmd, input logic [N-1:0] mask);
        pmp_pkg::duty_report_t rep;
        int count;
        count = (cmd == CMD_CONFIG) ? 2 * N : N;
        if (cmd == CMD_UPDATE) begin
            for (int p = 0; p < N; p++) begin
                if (mask[p]) begin
                    exp_q.push_back(expected_write(cmd, 2 * p, period, mod_params));
                    exp_q.push_back(expected_write(cmd, 2 * p + 1, period, mod_params));
                    rep.phase = 2'(p);
                    rep.duty = 16'(shed_duty(p, period, mod_params));
                    rep_exp_q.push_back(rep);
                end
            end
        end else begin
            for (int i = 0; i < count; i++) begin
                exp_q.push_back(expected_write(cmd, i, period, mod_params));
            end
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 || rep_exp_q.size() > 0) begin
            if (cycles == 2000) begin
                abort_run($sformatf("Timed out in %s waiting for expected writes", test_name));
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic wait_status(input logic level);
        int cycles;
        cycles = 0;
        while (modulator_status !== level) begin
            if (cycles == 500) begin
                abort_run($sformatf("Timed out in %s waiting for modulator status", test_name));
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target) begin
            if (cycles == 500) begin
                abort_run($sformatf("Timed out in %s waiting for done", test_name));
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Ready is random or held high, changed just after the rising edge
    initial begin
        write_ready = 1'b0;
        ready_rng = 32'd3018;
        forever begin
            @(posedge clock);
            #1;
            if (random_ready) begin
                ready_rng = xorshift32(ready_rng);
                write_ready = ready_rng[7];
            end else begin
                write_ready = 1'b1;
            end
        end
    end

    // Sampled mid-cycle where every output is settled
    always @(negedge clock) begin
        if (rst_n) begin
            if (write_valid && write_ready) begin
                got_q.push_back(write_req);
                write_count++;
            end
            if (duty_report_valid) begin
                rep_got_q.push_back(duty_report);
            end
            if (done) begin
                done_count++;
            end
        end
    end

    always @(posedge clock) begin
        pmp_pkg::write_req_t got;
        pmp_pkg::write_req_t want;
        pmp_pkg::duty_report_t rep;
        pmp_pkg::duty_report_t rep_want;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected write to %0h in %s", got.addr, test_name));
            end else begin
                want = exp_q.pop_front();
                check_value("addr", 32'(want.addr), 32'(got.addr));
                check_value("data", want.data, got.data);
                check_value("last", 32'(want.last), 32'(got.last));
            end
        end
        while (rep_got_q.size() > 0) begin
            rep = rep_got_q.pop_front();
            if (rep_exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected duty report in %s", test_name));
            end else begin
                rep_want = rep_exp_q.pop_front();
                check_value("report phase", 32'(rep_want.phase), 32'(rep.phase));
                check_value("report duty", 32'(rep_want.duty), 32'(rep.duty));
            end
        end
    end

    initial begin
        int quiet_start;
        rst_n = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = '0;
        period = 16'd1000;
        mod_params = '0;
        mod_params.deadtime = 16'd50;
        mod_params.n_active = 3'd3;
        random_ready = 1'b0;
        duty_rng = 32'd3018;
        test_name = "reset";
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;

        test_name = "configure";
        expect_sequence(CMD_CONFIG, '0);
        pulse_command(CMD_CONFIG);
        wait_done(1);
        wait_drained();
        // Give a stray second pulse time to show up before counting
        for (int c = 0; c < 20; c++) begin
            next_cycle();
        end
        check_value("done pulses", 32'd1, 32'(done_count));

        test_name = "start_stop";
        expect_sequence(CMD_START, '0);
        pulse_command(CMD_START);
        wait_status(1'b1);
        wait_drained();
        expect_sequence(CMD_STOP, '0);
        pulse_command(CMD_STOP);
        wait_status(1'b0);
        wait_drained();

        test_name = "update_all";
        expect_sequence(CMD_START, '0);
        pulse_command(CMD_START);
        wait_status(1'b1);
        wait_drained();
        for (int i = 0; i < N; i++) begin
            mod_params.duty[i] = random_duty();
        end
        expect_sequence(CMD_UPDATE, 4'b1111);
        issue_update(4'b1111);
        wait_drained();

        // Two active phases, phase 1 asks for more than a full period
        test_name = "shed_two_phases";
        mod_params.n_active = 3'd1;
        mod_params.duty[0] = 16'd300;
        mod_params.duty[1] = 16'd1500;
        mod_params.duty[2] = 16'd700;
        mod_params.duty[3] = 16'd900;
        expect_sequence(CMD_UPDATE, 4'b1111);
        issue_update(4'b1111);
        wait_drained();

        test_name = "random_ready";
        random_ready = 1'b1;
        expect_sequence(CMD_STOP, '0);
        pulse_command(CMD_STOP);
        wait_status(1'b0);
        wait_drained();
        for (int i = 0; i < N; i++) begin
            mod_params.duty[i] = random_duty();
        end
        // These stay pending until the modulator runs again
        issue_update(4'b1010);
        expect_sequence(CMD_CONFIG, '0);
        pulse_command(CMD_CONFIG);
        wait_done(2);
        wait_drained();
        expect_sequence(CMD_START, '0);
        expect_sequence(CMD_UPDATE, 4'b1010);
        pulse_command(CMD_START);
        wait_status(1'b1);
        wait_drained();
        // Only the two configure sequences pulse done
        check_value("done pulses", 32'd2, 32'(done_count));

        test_name = "update_after_stop";
        expect_sequence(CMD_STOP, '0);
        pulse_command(CMD_STOP);
        wait_status(1'b0);
        wait_drained();
        issue_update(4'b1111);
        quiet_start = write_count;
        for (int c = 0; c < 200; c++) begin
            next_cycle();
            if (write_count != quiet_start) begin
                abort_run("A write was issued while the modulator was stopped");
            end
        end

        if (error_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "Errors were found");
        end
    end

endmodule

/* verilog.f */
+incdir+source
source/pmp_pkg.sv
source/pmp_shift_calculator.sv
source/pmp_phase_shedder.sv
source/pmp_management_core.sv
source/pmp_operating_core.sv
source/buck_pre_modulation_processor.sv
tests/pmp_checker.sv
tests/tb_pmp.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pmp -f verilog.f -o Vtb_pmp

status=0
./obj_dir/Vtb_pmp > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without completing"
    exit 1
fi
echo "Simulation completed"
